// ==== rtl/rle_pkg.sv ====
////////////////////////////////////////////////////////////
// run-length codec shared types
////////////////////////////////////////////////////////////

package rle_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned DATA_W = 8;  // sample width
  localparam int unsigned CNT_W  = 4;  // run length minus one

  typedef logic [DATA_W-1:0] smp_t;  // one sample value
  typedef logic [CNT_W-1:0]  cnt_t;  // repeat count, 0 means a single sample

  ////////////////////////////////////////////////////////////
  // stream beats
  ////////////////////////////////////////////////////////////

  // sample stream, 10 bits
  // ready travels next to it as a separate level
  typedef struct packed {
    logic valid;  // beat present
    logic last;   // end of packet
    smp_t data;   // sample value
  } smp_beat_t;

  // compressed stream, 14 bits
  typedef struct packed {
    logic valid;  // word present
    logic last;   // final word of a packet
    cnt_t count;  // run length minus one
    smp_t data;   // repeated value
  } rle_beat_t;

  ////////////////////////////////////////////////////////////
  // encoder FSM
  ////////////////////////////////////////////////////////////

  // ENC_EMPTY  no run held
  // ENC_RUN    a run is being counted
  // ENC_FLUSH  second word of a split last sample still pending
  typedef enum logic [1:0] {
    ENC_EMPTY,
    ENC_RUN,
    ENC_FLUSH
  } enc_state_t;

endpackage

// ==== rtl/rle_encoder.sv ====
////////////////////////////////////////////////////////////
// run-length encoder
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rle_encoder (
  input  logic                sti,        // clock
  input  logic                rst_n,
  input  logic                ctl_rst,    // clear run state
  input  logic                cfg_ena,    // low selects bypass
  input  rle_pkg::smp_beat_t  in_beat,
  output logic                in_ready,
  output rle_pkg::rle_beat_t  enc_beat,
  input  logic                enc_ready
);

  rle_pkg::enc_state_t state, state_nxt;

  // held run, payload only
  rle_pkg::smp_t run_val, run_val_nxt;
  rle_pkg::cnt_t run_cnt, run_cnt_nxt;
  logic          run_last, run_last_nxt;  // last flag of a pending flush word

  logic rdy_en;  // keeps in_ready low on the first cycle after reset

  // output register
  logic          out_vld;
  logic          out_last;
  rle_pkg::cnt_t out_cnt;
  rle_pkg::smp_t out_data;

  // load request into the output register
  logic          ld;
  logic          ld_last;
  rle_pkg::cnt_t ld_cnt;
  rle_pkg::smp_t ld_data;

  logic out_free;  // output register can take a word this cycle
  logic in_fire;
  logic same;      // sample equals held value
  logic split;     // held run must close before this sample

  ////////////////////////////////////////////////////////////
  // handshake and compare
  ////////////////////////////////////////////////////////////

  assign out_free = ~out_vld | enc_ready;
  assign in_ready = rdy_en & (state != rle_pkg::ENC_FLUSH) & out_free;
  assign in_fire  = in_beat.valid & in_ready;

  assign same  = (in_beat.data == run_val);
  assign split = ~cfg_ena | ~same | (run_cnt == '1);  // '1 is a full run of 16

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt    = state;
    run_val_nxt  = run_val;
    run_cnt_nxt  = run_cnt;
    run_last_nxt = run_last;
    ld           = 1'b0;
    ld_last      = in_beat.last;  // default word is the sample itself
    ld_cnt       = '0;
    ld_data      = in_beat.data;
    case (state)
      rle_pkg::ENC_EMPTY: begin
        if (in_fire) begin
          if (in_beat.last | ~cfg_ena) begin
            ld = 1'b1;  // single sample word goes straight out
          end else begin
            run_val_nxt = in_beat.data;  // open a new run
            run_cnt_nxt = '0;
            state_nxt   = rle_pkg::ENC_RUN;
          end
        end
      end
      rle_pkg::ENC_RUN: begin
        if (in_fire) begin
          if (!split) begin
            if (in_beat.last) begin
              ld        = 1'b1;  // last closes the run including itself
              ld_cnt    = run_cnt + 1'b1;
              state_nxt = rle_pkg::ENC_EMPTY;
            end else begin
              run_cnt_nxt = run_cnt + 1'b1;
            end
          end else begin
            // emit old run, new sample starts the next one
            ld           = 1'b1;
            ld_last      = 1'b0;
            ld_cnt       = run_cnt;
            ld_data      = run_val;
            run_val_nxt  = in_beat.data;
            run_cnt_nxt  = '0;
            run_last_nxt = in_beat.last;
            if (in_beat.last | ~cfg_ena) begin
              state_nxt = rle_pkg::ENC_FLUSH;  // its word follows next cycle
            end else begin
              state_nxt = rle_pkg::ENC_RUN;
            end
          end
        end
      end
      rle_pkg::ENC_FLUSH: begin
        if (out_free) begin
          ld        = 1'b1;
          ld_last   = run_last;
          ld_cnt    = run_cnt;
          ld_data   = run_val;
          state_nxt = rle_pkg::ENC_EMPTY;
        end
      end
      default: state_nxt = rle_pkg::ENC_EMPTY;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (!rst_n) begin
      rdy_en  <= 1'b0;
      state   <= rle_pkg::ENC_EMPTY;
      out_vld <= 1'b0;
    end else begin
      rdy_en <= 1'b1;
      if (ctl_rst) begin
        state   <= rle_pkg::ENC_EMPTY;  // drop run and pending word
        out_vld <= 1'b0;
      end else begin
        state <= state_nxt;
        if (ld) out_vld <= 1'b1;
        else if (enc_ready) out_vld <= 1'b0;
      end
    end
  end

  always_ff @(posedge sti) begin
    run_val  <= run_val_nxt;
    run_cnt  <= run_cnt_nxt;
    run_last <= run_last_nxt;
    if (ld) begin
      out_last <= ld_last;
      out_cnt  <= ld_cnt;
      out_data <= ld_data;
    end
  end

  assign enc_beat = '{valid: out_vld, last: out_last, count: out_cnt, data: out_data};

endmodule

// ==== rtl/rle_fifo.sv ====
////////////////////////////////////////////////////////////
// compressed word FIFO
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rle_fifo #(
  parameter int unsigned DEPTH = 4  // number of words
)(
  input  logic                sti,
  input  logic                rst_n,
  input  logic                ctl_rst,  // drop all contents
  input  rle_pkg::rle_beat_t  wr_beat,
  output logic                wr_ready,
  output rle_pkg::rle_beat_t  rd_beat,
  input  logic                rd_ready
);

  localparam int unsigned AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // storage, no reset
  logic          mem_last [DEPTH];
  rle_pkg::cnt_t mem_cnt  [DEPTH];
  rle_pkg::smp_t mem_data [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   occ;      // occupancy, 0..DEPTH

  logic wr_fire;
  logic rd_fire;

  assign wr_ready = (occ != (AW+1)'(DEPTH));  // not full
  assign wr_fire  = wr_beat.valid & wr_ready;
  assign rd_fire  = rd_beat.valid & rd_ready;

  ////////////////////////////////////////////////////////////
  // pointers and occupancy
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (!rst_n || ctl_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      occ    <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;  // wrap for any depth
      end
      if (rd_fire) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_fire, rd_fire})
        2'b10:   occ <= occ + 1'b1;
        2'b01:   occ <= occ - 1'b1;
        default: occ <= occ;  // both or neither
      endcase
    end
  end

  always_ff @(posedge sti) begin
    if (wr_fire) begin
      mem_last[wr_ptr] <= wr_beat.last;
      mem_cnt[wr_ptr]  <= wr_beat.count;
      mem_data[wr_ptr] <= wr_beat.data;
    end
  end

  // head of queue, valid when not empty
  assign rd_beat = '{valid: (occ != '0),
                     last:  mem_last[rd_ptr],
                     count: mem_cnt[rd_ptr],
                     data:  mem_data[rd_ptr]};

endmodule

// ==== rtl/rle_decoder.sv ====
////////////////////////////////////////////////////////////
// run-length decoder
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rle_decoder (
  input  logic                sti,
  input  logic                rst_n,
  input  logic                ctl_rst,     // abandon current word
  input  rle_pkg::rle_beat_t  word_beat,
  output logic                word_ready,
  output rle_pkg::smp_beat_t  out_beat,
  input  logic                out_ready
);

  logic          busy;      // a word is being expanded
  logic          cur_last;  // word closes a packet
  rle_pkg::smp_t cur_data;
  rle_pkg::cnt_t left;      // samples still due after the current one

  logic out_fire;
  logic final_smp;          // current sample is the word's last
  logic word_fire;

  ////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////

  assign final_smp = (left == '0);
  assign out_fire  = busy & out_ready;

  // take the next word when idle or as the final sample leaves
  assign word_ready = ~busy | (out_fire & final_smp);
  assign word_fire  = word_beat.valid & word_ready;

  ////////////////////////////////////////////////////////////
  // expansion
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (!rst_n) begin
      busy <= 1'b0;
    end else if (ctl_rst) begin
      busy <= 1'b0;
    end else if (word_fire) begin
      busy <= 1'b1;  // back to back words keep busy high
    end else if (out_fire && final_smp) begin
      busy <= 1'b0;
    end
  end

  always_ff @(posedge sti) begin
    if (word_fire) begin
      cur_last <= word_beat.last;
      cur_data <= word_beat.data;
      left     <= word_beat.count;  // count+1 samples in total
    end else if (out_fire && !final_smp) begin
      left <= left - 1'b1;
    end
  end

  // last only on the final sample of a closing word
  assign out_beat = '{valid: busy,
                      last:  cur_last & final_smp,
                      data:  cur_data};

endmodule

// ==== rtl/rle_codec.sv ====
////////////////////////////////////////////////////////////
// run-length codec top
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rle_codec #(
  parameter int unsigned FIFO_DEPTH = 4  // compressed words in flight
)(
  input  logic                sti,
  input  logic                rst_n,
  input  logic                ctl_rst,   // clears run state, FIFO, decoder
  input  logic                cfg_ena,   // low selects bypass
  input  rle_pkg::smp_beat_t  in_beat,
  output logic                in_ready,
  output rle_pkg::smp_beat_t  out_beat,
  input  logic                out_ready,
  output rle_pkg::rle_beat_t  cmp_mon    // copy of each word entering the FIFO
);

  rle_pkg::rle_beat_t enc_beat;   // encoder to FIFO
  logic               enc_ready;
  rle_pkg::rle_beat_t fifo_beat;  // FIFO to decoder
  logic               fifo_ready;

  ////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////

  rle_encoder u_encoder (
    .sti       (sti),
    .rst_n     (rst_n),
    .ctl_rst   (ctl_rst),
    .cfg_ena   (cfg_ena),
    .in_beat   (in_beat),
    .in_ready  (in_ready),
    .enc_beat  (enc_beat),
    .enc_ready (enc_ready)
  );

  rle_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .sti      (sti),
    .rst_n    (rst_n),
    .ctl_rst  (ctl_rst),
    .wr_beat  (enc_beat),
    .wr_ready (enc_ready),
    .rd_beat  (fifo_beat),
    .rd_ready (fifo_ready)
  );

  rle_decoder u_decoder (
    .sti        (sti),
    .rst_n      (rst_n),
    .ctl_rst    (ctl_rst),
    .word_beat  (fifo_beat),
    .word_ready (fifo_ready),
    .out_beat   (out_beat),
    .out_ready  (out_ready)
  );

  // monitor tap, valid only on actual transfers
  always_comb begin
    cmp_mon       = enc_beat;
    cmp_mon.valid = enc_beat.valid & enc_ready;
  end

endmodule

// ==== bench/rle_codec_checker.sv ====
////////////////////////////////////////////////////////////
// codec handshake assertions
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rle_codec_checker (
  input logic               sti,
  input logic               rst_n,
  input logic               ctl_rst,
  input rle_pkg::smp_beat_t in_beat,
  input logic               in_ready,
  input rle_pkg::rle_beat_t enc_beat,
  input logic               enc_ready,
  input rle_pkg::smp_beat_t out_beat,
  input logic               out_ready,
  input rle_pkg::rle_beat_t cmp_mon
);

  int unsigned fail_cnt = 0;  // read by the testbench at the end

  // stalled beats hold until they transfer
  in_hold: assert property (@(posedge sti) disable iff (!rst_n)
    in_beat.valid && !in_ready |=> $stable(in_beat))
    else begin $error("in_beat changed while stalled"); fail_cnt++; end

  enc_hold: assert property (@(posedge sti) disable iff (!rst_n)
    enc_beat.valid && !enc_ready && !ctl_rst |=> $stable(enc_beat))
    else begin $error("enc_beat changed while stalled"); fail_cnt++; end

  out_hold: assert property (@(posedge sti) disable iff (!rst_n)
    out_beat.valid && !out_ready && !ctl_rst |=> $stable(out_beat))
    else begin $error("out_beat changed while stalled"); fail_cnt++; end

  // quiet outputs right after a reset edge
  rst_quiet: assert property (@(posedge sti)
    !rst_n |=> !in_ready && !enc_beat.valid && !out_beat.valid && !cmp_mon.valid)
    else begin $error("output active after reset"); fail_cnt++; end

endmodule

bind rle_codec rle_codec_checker u_chk (
  .sti (sti), .rst_n (rst_n), .ctl_rst (ctl_rst),
  .in_beat (in_beat), .in_ready (in_ready),
  .enc_beat (enc_beat), .enc_ready (enc_ready),
  .out_beat (out_beat), .out_ready (out_ready),
  .cmp_mon (cmp_mon)
);

// ==== bench/rle_codec_tb.sv ====
////////////////////////////////////////////////////////////
// run-length codec testbench
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rle_codec_tb;

  localparam int NUM_PKT = 20;
  localparam int TIMEOUT = 2000;            // cycles per wait
  localparam logic [31:0] SEED = 32'd98014;

  // table row holding one run of equal samples
  typedef struct packed {
    rle_pkg::smp_t val;   // sample value
    int            len;   // run length
    bit            last;  // last on the final sample
    bit            ena;   // encoder on, else bypass
    bit            clr;   // samples dropped by a ctl_rst pulse
  } pkt_t;

  logic               sti;
  logic               rst_n;
  logic               ctl_rst;
  logic               cfg_ena;
  rle_pkg::smp_beat_t in_beat;
  logic               in_ready;
  rle_pkg::smp_beat_t out_beat;
  logic               out_ready;
  rle_pkg::rle_beat_t cmp_mon;

  pkt_t               tbl [NUM_PKT];
  rle_pkg::rle_beat_t exp_words [$];  // expected monitor words
  rle_pkg::smp_beat_t exp_smps [$];   // expected output samples
  int                 words_upto [NUM_PKT];  // words due once packet e is through
  int                 smps_upto [NUM_PKT];   // samples due once packet e is through
  rle_pkg::rle_beat_t word_exp;
  rle_pkg::smp_beat_t smp_exp;
  logic [31:0]        rnd;
  int                 n_words;
  int                 n_smps;

  rle_codec #(
    .FIFO_DEPTH (4)
  ) u_rle_codec (
    .sti       (sti),
    .rst_n     (rst_n),
    .ctl_rst   (ctl_rst),
    .cfg_ena   (cfg_ena),
    .in_beat   (in_beat),
    .in_ready  (in_ready),
    .out_beat  (out_beat),
    .out_ready (out_ready),
    .cmp_mon   (cmp_mon)
  );

  initial begin
    sti = 1'b0;
    forever #4 sti = ~sti;  // 8 ns period
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("Fail at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp));
    end
  endtask

  task automatic add_word(input rle_pkg::smp_t d, input int c, input logic l);
    exp_words.push_back('{valid: 1'b1, last: l, count: rle_pkg::cnt_t'(c), data: d});
  endtask

  // reference model straight from the run rules
  task automatic build_expected();
    int            e;
    int            k;
    int            rc;    // held run length minus one
    bit            held;
    rle_pkg::smp_t rv;
    rle_pkg::smp_t d;
    logic          l;
    held = 0;
    rc   = 0;
    rv   = '0;
    for (e = 0; e < NUM_PKT; e++) begin
      if (tbl[e].clr) begin
        held = 0;  // run is thrown away so nothing comes out
      end else begin
        for (k = 0; k < tbl[e].len; k++) begin
          d = tbl[e].val;
          l = tbl[e].last && (k == tbl[e].len - 1);
          exp_smps.push_back('{valid: 1'b1, last: l, data: d});
          if (!tbl[e].ena) begin
            add_word(d, 0, l);  // bypass gives one word per sample
          end else begin
            if (held && (d != rv || rc == 15)) begin
              add_word(rv, rc, 1'b0);  // value change or 16 reached
              held = 0;
            end
            if (held) begin
              rc++;
            end else begin
              rv   = d;
              rc   = 0;
              held = 1;
            end
            if (l) begin
              add_word(rv, rc, 1'b1);
              held = 0;
            end
          end
        end
      end
      words_upto[e] = exp_words.size();
      smps_upto[e]  = exp_smps.size();
    end
  endtask

  task automatic send_sample(input rle_pkg::smp_t d, input logic l, input logic e);
    int waited;
    waited  = 0;
    in_beat = '{valid: 1'b1, last: l, data: d};
    cfg_ena = e;
    do begin
      @(negedge sti);
      waited++;
      if (waited > TIMEOUT) abort_run("timeout: in_ready never came back");
    end while (!in_ready);
    @(posedge sti);  // transfer edge
    #1;
    in_beat.valid = 1'b0;
  endtask

  task automatic wait_drained(input int n_w, input int n_s);
    int waited;
    waited = 0;
    while (n_words < n_w || n_smps < n_s) begin
      @(posedge sti);
      waited++;
      if (waited > TIMEOUT) abort_run("timeout: expected output never arrived");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // out_ready throttle and output monitor
  ////////////////////////////////////////////////////////////

  initial begin
    out_ready = 1'b0;
    rnd       = SEED;
    forever begin
      @(posedge sti);
      #1;
      rnd       = xorshift32(rnd);
      out_ready = rnd[0];  // about half the cycles
    end
  end

  // sampled mid cycle ahead of the transfer edge
  always @(negedge sti) begin
    if (rst_n) begin
      if (cmp_mon.valid) begin
        if (exp_words.size() == 0) abort_run("compressed word seen with none expected");
        word_exp = exp_words.pop_front();
        check_value(32'(cmp_mon.data), 32'(word_exp.data), "word data");
        check_value(32'(cmp_mon.count), 32'(word_exp.count), "word count");
        check_value(32'(cmp_mon.last), 32'(word_exp.last), "word last");
        n_words++;
      end
      if (out_beat.valid && out_ready) begin
        if (exp_smps.size() == 0) abort_run("output sample seen with none expected");
        smp_exp = exp_smps.pop_front();
        check_value(32'(out_beat.data), 32'(smp_exp.data), "sample data");
        check_value(32'(out_beat.last), 32'(smp_exp.last), "sample last");
        n_smps++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    int e;
    int k;
    rst_n   = 1'b0;
    ctl_rst = 1'b0;
    cfg_ena = 1'b1;
    in_beat = '0;
    n_words = 0;
    n_smps  = 0;
    tbl = '{
      '{8'h11,  3, 1'b0, 1'b1, 1'b0}, '{8'h22,  1, 1'b0, 1'b1, 1'b0},  // short merges
      '{8'h33,  5, 1'b1, 1'b1, 1'b0}, '{8'h44, 40, 1'b1, 1'b1, 1'b0},  // 16 + 16 + 8
      '{8'h55,  4, 1'b0, 1'b1, 1'b0}, '{8'h66,  1, 1'b1, 1'b1, 1'b0},  // differing last
      '{8'h66,  3, 1'b1, 1'b1, 1'b0}, '{8'h77,  1, 1'b1, 1'b1, 1'b0},  // not merged
      '{8'h99,  3, 1'b0, 1'b0, 1'b0}, '{8'haa,  2, 1'b0, 1'b0, 1'b0},  // bypass
      '{8'haa,  1, 1'b1, 1'b0, 1'b0}, '{8'hbb, 10, 1'b0, 1'b1, 1'b0},
      '{8'hbb, 10, 1'b1, 1'b1, 1'b0}, '{8'hdd, 16, 1'b1, 1'b1, 1'b0},  // 20 split then 16
      '{8'he1, 17, 1'b1, 1'b1, 1'b0}, '{8'hcc,  5, 1'b0, 1'b1, 1'b1},  // 16 + 1 then cleared
      '{8'hcc,  2, 1'b1, 1'b1, 1'b0}, '{8'hf0,  2, 1'b0, 1'b1, 1'b0},
      '{8'h0f,  1, 1'b0, 1'b1, 1'b0}, '{8'hf0,  6, 1'b1, 1'b1, 1'b0}
    };
    build_expected();
    repeat (3) @(posedge sti);
    #1;
    rst_n = 1'b1;
    for (e = 0; e < NUM_PKT; e++) begin
      for (k = 0; k < tbl[e].len; k++) begin
        send_sample(tbl[e].val, tbl[e].last && (k == tbl[e].len - 1), tbl[e].ena);
      end
      if (tbl[e].clr) begin
        wait_drained(words_upto[e], smps_upto[e]);  // nothing in flight before the clear
        @(posedge sti);
        #1;
        ctl_rst = 1'b1;
        @(posedge sti);
        #1;
        ctl_rst = 1'b0;
      end
    end
    wait_drained(words_upto[NUM_PKT-1], smps_upto[NUM_PKT-1]);
    repeat (20) @(posedge sti);  // catch stray output
    $display("%0d words and %0d samples compared", n_words, n_smps);
    if (u_rle_codec.u_chk.fail_cnt != 0) begin
      $display("checker assertions failed %0d times", u_rle_codec.u_chk.fail_cnt);
      $display("Test FAILED");
      $fatal(1, "assertion failures");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

// ==== all.f ====
rtl/rle_pkg.sv
rtl/rle_encoder.sv
rtl/rle_fifo.sv
rtl/rle_decoder.sv
rtl/rle_codec.sv
bench/rle_codec_checker.sv
bench/rle_codec_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the codec testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=rle_codec_sim

verilator --binary --assert -f all.f --top-module rle_codec_tb -Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

"./$OBJ/$BIN" +verilator+error+limit+100 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Test OK$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
